// ==== verilog/fb_defines.svh ====
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// picture size in pixels
`define FB_COLS     128
`define FB_ROWS     128

// one pixel address, row in the upper half and column in the lower half
`define FB_ADDR_W   14

`define FB_H_FRONT  8     // pixels after the active area
`define FB_H_SYNC   16
`define FB_H_BACK   8
`define FB_H_TOTAL  (`FB_COLS + `FB_H_FRONT + `FB_H_SYNC + `FB_H_BACK)

// vertical timing in whole lines, a frame of 136 lines is 21760 clocks
`define FB_V_FRONT  2
`define FB_V_SYNC   2
`define FB_V_BACK   4
`define FB_V_TOTAL  (`FB_ROWS + `FB_V_FRONT + `FB_V_SYNC + `FB_V_BACK)

`endif

// ==== verilog/fb_pkg.sv ====
`include "fb_defines.svh"

package fb_pkg;

   // same 14 bits seen as a memory index or as row and column
   // rc[1] is the row and rc[0] the column, so row-major order is the flat index
   typedef union packed {
      logic [`FB_ADDR_W-1:0]          flat;   // plane memory index
      logic [1:0][`FB_ADDR_W/2-1:0]   rc;     // row, column
   } pix_addr_u;

   // one bit per plane
   // bit 2 red, bit 1 green, bit 0 blue
   typedef logic [2:0] rgb_t;

endpackage

// ==== verilog/fb_scan_if.sv ====
`timescale 1ns/1ns

interface fb_scan_if;
   import fb_pkg::*;

   logic      hsync;    // active low
   logic      vsync;    // active low
   logic      active;   // position lies inside the picture
   pix_addr_u addr;     // current scan position

   // driven by the scan timing stage
   modport source (
      output hsync,
      output vsync,
      output active,
      output addr
   );

   // read by later pipeline stages
   modport sink (
      input hsync,
      input vsync,
      input active,
      input addr
   );

endinterface

// ==== verilog/scan_timing.sv ====
`timescale 1ns/1ns
`include "fb_defines.svh"

module scan_timing (
   input logic       clk,
   input logic       arst_n,
   fb_scan_if.source scan
);
   localparam int H_W   = $clog2(`FB_H_TOTAL);
   localparam int V_W   = $clog2(`FB_V_TOTAL);
   localparam int COL_W = `FB_ADDR_W / 2;

   localparam int HS_START = `FB_COLS + `FB_H_FRONT;   // first pixel of hsync
   localparam int HS_END   = HS_START + `FB_H_SYNC;
   localparam int VS_START = `FB_ROWS + `FB_V_FRONT;   // first line of vsync
   localparam int VS_END   = VS_START + `FB_V_SYNC;

   logic [H_W-1:0] h_cnt;   // pixel within line
   logic [V_W-1:0] v_cnt;   // line within frame
   logic           h_wrap;
   logic           v_wrap;

   assign h_wrap = (h_cnt == H_W'(`FB_H_TOTAL - 1));
   assign v_wrap = (v_cnt == V_W'(`FB_V_TOTAL - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         h_cnt <= h_wrap ? '0 : h_cnt + 1'b1;
         if (h_wrap) begin
            v_cnt <= v_wrap ? '0 : v_cnt + 1'b1;   // step once per line
         end
      end
   end

   // position is decoded straight from the counters, no extra delay
   always_comb begin
      scan.hsync  = !((h_cnt >= H_W'(HS_START)) && (h_cnt < H_W'(HS_END)));
      scan.vsync  = !((v_cnt >= V_W'(VS_START)) && (v_cnt < V_W'(VS_END)));
      scan.active = (h_cnt < H_W'(`FB_COLS)) && (v_cnt < V_W'(`FB_ROWS));
      scan.addr.rc[1] = v_cnt[COL_W-1:0];   // row
      scan.addr.rc[0] = h_cnt[COL_W-1:0];   // column
   end

   hsync_width: assert property (
      @(posedge clk) disable iff (!arst_n)
      $fell(scan.hsync) |=> (!scan.hsync) [* (`FB_H_SYNC - 1)] ##1 scan.hsync
   ) else $error("hsync pulse is not %0d cycles long", `FB_H_SYNC);

endmodule

// ==== verilog/plane_ram.sv ====
`timescale 1ns/1ns
`include "fb_defines.svh"

module plane_ram (
   input  logic                  clk,
   input  logic                  rd_en,
   input  logic [`FB_ADDR_W-1:0] rd_addr,
   output logic                  rd_bit,
   input  logic                  wr_en,
   input  logic [`FB_ADDR_W-1:0] wr_addr,
   input  logic                  wr_bit
);
   localparam int DEPTH = 1 << `FB_ADDR_W;

   logic mem [0:DEPTH-1];   // one bit per pixel

   // scan-out port, output holds while the beam is blanked
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_bit <= mem[rd_addr];   // old bit on a same-cycle write
      end
   end

   // host port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_bit;
      end
   end

endmodule

// ==== verilog/host_write.sv ====
`timescale 1ns/1ns
`include "fb_defines.svh"

module host_write (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  req,
   output logic                  ack,
   input  fb_pkg::pix_addr_u     wr_addr,
   input  fb_pkg::rgb_t          wr_color,
   output logic                  mem_we,
   output logic [`FB_ADDR_W-1:0] mem_addr,
   output fb_pkg::rgb_t          mem_color
);
   localparam logic IDLE  = 1'b0;
   localparam logic ACKED = 1'b1;

   logic state;
   logic take;   // new request seen while idle

   assign take = (state == IDLE) && req;
   assign ack  = (state == ACKED);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= IDLE;
         mem_we <= 1'b0;
      end else begin
         mem_we <= take;   // single pulse on entry to ACKED
         case (state)
            IDLE: begin
               if (req) begin
                  state <= ACKED;
               end
            end
            ACKED: begin
               if (!req) begin
                  state <= IDLE;   // host released, ready for the next one
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         mem_addr  <= wr_addr.flat;
         mem_color <= wr_color;
      end
   end

   req_data_stable: assert property (
      @(posedge clk) disable iff (!arst_n)
      (req && !ack) |=> $stable(wr_addr) && $stable(wr_color)
   ) else $error("host changed address or colour during a request");

endmodule

// ==== verilog/pixel_stage.sv ====
`timescale 1ns/1ns

module pixel_stage (
   input  logic         clk,
   input  logic         arst_n,
   fb_scan_if.sink      scan,
   input  fb_pkg::rgb_t plane_bits,
   output logic         hsync,
   output logic         vsync,
   output logic         de,
   output fb_pkg::rgb_t color
);
   logic hsync_d;
   logic vsync_d;
   logic active_d;   // lines up with the RAM read data

   // controls wait one clock for the plane memories
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hsync_d  <= 1'b1;
         vsync_d  <= 1'b1;
         active_d <= 1'b0;
      end else begin
         hsync_d  <= scan.hsync;
         vsync_d  <= scan.vsync;
         active_d <= scan.active;
      end
   end

   // output registers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hsync <= 1'b1;
         vsync <= 1'b1;
         de    <= 1'b0;
         color <= '0;
      end else begin
         hsync <= hsync_d;
         vsync <= vsync_d;
         de    <= active_d;
         color <= active_d ? plane_bits : '0;   // black during blanking
      end
   end

   sync_outside_active: assert property (
      @(posedge clk) disable iff (!arst_n)
      de |-> (hsync && vsync)
   ) else $error("sync pulse inside the active area");

endmodule

// ==== verilog/fb_display.sv ====
`timescale 1ns/1ns
`include "fb_defines.svh"

module fb_display (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  req,
   input  logic [`FB_ADDR_W-1:0] wr_addr,
   input  logic [2:0]            wr_color,
   output logic                  ack,
   output logic                  hsync,
   output logic                  vsync,
   output logic                  de,
   output logic                  red,
   output logic                  green,
   output logic                  blue
);
   import fb_pkg::*;

   pix_addr_u             host_addr;
   rgb_t                  host_color;
   logic                  mem_we;
   logic [`FB_ADDR_W-1:0] mem_addr;
   rgb_t                  mem_color;
   rgb_t                  plane_bits;   // read bits, one per plane
   rgb_t                  pix_color;

   fb_scan_if scan_bus ();

   assign host_addr.flat = wr_addr;   // host gives the flat index
   assign host_color     = wr_color;

   scan_timing u_scan (
      .clk    (clk),
      .arst_n (arst_n),
      .scan   (scan_bus)
   );

   host_write u_host (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (req),
      .ack       (ack),
      .wr_addr   (host_addr),
      .wr_color  (host_color),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_color (mem_color)
   );

   for (genvar i = 0; i < $bits(rgb_t); i++) begin : g_plane
      plane_ram u_ram (
         .clk     (clk),
         .rd_en   (scan_bus.active),
         .rd_addr (scan_bus.addr.flat),
         .rd_bit  (plane_bits[i]),
         .wr_en   (mem_we),
         .wr_addr (mem_addr),
         .wr_bit  (mem_color[i])
      );
   end

   pixel_stage u_pixel (
      .clk        (clk),
      .arst_n     (arst_n),
      .scan       (scan_bus),
      .plane_bits (plane_bits),
      .hsync      (hsync),
      .vsync      (vsync),
      .de         (de),
      .color      (pix_color)
   );

   assign red   = pix_color[2];
   assign green = pix_color[1];
   assign blue  = pix_color[0];

endmodule

// ==== tests/fb_display_tb.sv ====
`timescale 1ns/1ns

module fb_display_tb;
   localparam int COLS       = 128;
   localparam int ROWS       = 128;
   localparam int LINE_CLKS  = 160;
   localparam int HS_LEN     = 16;
   localparam int VS_LEN     = 2 * LINE_CLKS;   // two lines of vsync
   localparam int FRAME_CLKS = 136 * LINE_CLKS;
   localparam int N_WRITES   = 200;
   localparam int TIMEOUT_CYCLES = 3 * FRAME_CLKS + 4720;   // 70000

   logic        clk;
   logic        arst_n;
   logic        req;
   logic [13:0] wr_addr;
   logic [2:0]  wr_color;
   logic        ack;
   logic        hsync;
   logic        vsync;
   logic        de;
   logic        red;
   logic        green;
   logic        blue;

   int         seed = 32'h656e74f6;
   int         cycles = 0;
   logic [2:0] model [int];   // written colour per flat index

   logic       hs_q, vs_q, de_q;   // previous samples
   logic       hs_seen, vs_seen;
   int         hs_low, hs_gap, vs_low, vs_gap;
   int         de_run, de_lines, pix_idx, frames;
   int         hand_wait, checked_px, cmp_idx;
   logic       cmp_valid;
   logic [2:0] exp_color, got_color;

   fb_display dut (
      .clk      (clk),
      .arst_n   (arst_n),
      .req      (req),
      .wr_addr  (wr_addr),
      .wr_color (wr_color),
      .ack      (ack),
      .hsync    (hsync),
      .vsync    (vsync),
      .de       (de),
      .red      (red),
      .green    (green),
      .blue     (blue)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("test failed");
      $fatal(1, "stopped at the first error");
   endtask

   // one four-phase write, the model follows the host
   task automatic write_pixel(input logic [13:0] addr, input logic [2:0] color);
      @(negedge clk);
      wr_addr  = addr;
      wr_color = color;
      req      = 1'b1;
      model[int'(addr)] = color;
      while (!ack) @(negedge clk);
      req = 1'b0;
      while (ack) @(negedge clk);
   endtask

   // run lengths and the pixel index, taken at every rising edge
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hs_q       <= 1'b1;
         vs_q       <= 1'b1;
         de_q       <= 1'b0;
         hs_seen    <= 1'b0;
         vs_seen    <= 1'b0;
         hs_low     <= 0;
         hs_gap     <= 0;
         vs_low     <= 0;
         vs_gap     <= 0;
         de_run     <= 0;
         de_lines   <= 0;
         pix_idx    <= 0;
         frames     <= 0;
         hand_wait  <= 0;
         checked_px <= 0;
         cmp_valid  <= 1'b0;
      end else begin
         hs_q      <= hsync;
         vs_q      <= vsync;
         de_q      <= de;
         hs_low    <= hsync ? 0 : hs_low + 1;
         hs_gap    <= (hs_q && !hsync) ? 0 : hs_gap + 1;   // clocks since last fall
         vs_low    <= vsync ? 0 : vs_low + 1;
         vs_gap    <= (vs_q && !vsync) ? 0 : vs_gap + 1;
         de_run    <= de ? de_run + 1 : 0;
         hand_wait <= (req != ack) ? hand_wait + 1 : 0;
         if (hs_q && !hsync) begin
            hs_seen <= 1'b1;
         end
         if (vs_q && !vsync) begin
            vs_seen  <= 1'b1;
            frames   <= frames + 1;
            de_lines <= 0;
            pix_idx  <= 0;   // flat index restarts at row 0, column 0
         end else begin
            if (de && !de_q) begin
               de_lines <= de_lines + 1;
            end
            if (de) begin
               pix_idx <= pix_idx + 1;
            end
         end
         // frames from the second on hold every write
         cmp_valid <= de && (frames >= 1) && (model.exists(pix_idx) != 0);
         cmp_idx   <= pix_idx;
         got_color <= {red, green, blue};
         if (model.exists(pix_idx) != 0) begin
            exp_color <= model[pix_idx];
         end
         if (cmp_valid) begin
            checked_px <= checked_px + 1;
         end
      end
   end

   reset_state: assert property (@(posedge clk)
      (!arst_n || $rose(arst_n)) |->
         (!ack && hsync && vsync && !de && ({red, green, blue} == 3'b000))
   ) else abort_run($sformatf("mismatch at %0t ns: outputs left reset state", $time));

   hsync_len: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(hsync) |-> (hs_low == HS_LEN)
   ) else abort_run($sformatf("mismatch at %0t ns: hsync low for %0d cycles",
                              $time, $sampled(hs_low)));

   hsync_period: assert property (@(posedge clk) disable iff (!arst_n)
      ($fell(hsync) && hs_seen) |-> (hs_gap == LINE_CLKS - 1)
   ) else abort_run($sformatf("mismatch at %0t ns: hsync period %0d cycles",
                              $time, $sampled(hs_gap) + 1));

   vsync_len: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(vsync) |-> (vs_low == VS_LEN)
   ) else abort_run($sformatf("mismatch at %0t ns: vsync low for %0d cycles",
                              $time, $sampled(vs_low)));

   vsync_period: assert property (@(posedge clk) disable iff (!arst_n)
      ($fell(vsync) && vs_seen) |-> (vs_gap == FRAME_CLKS - 1)
   ) else abort_run($sformatf("mismatch at %0t ns: frame period %0d cycles",
                              $time, $sampled(vs_gap) + 1));

   de_per_line: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(de) |-> (de_run == COLS)
   ) else abort_run($sformatf("mismatch at %0t ns: de high for %0d cycles",
                              $time, $sampled(de_run)));

   de_per_frame: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(vsync) |-> (de_lines == ROWS)
   ) else abort_run($sformatf("mismatch at %0t ns: %0d lines carried de",
                              $time, $sampled(de_lines)));

   blank_black: assert property (@(posedge clk) disable iff (!arst_n)
      !de |-> ({red, green, blue} == 3'b000)
   ) else abort_run($sformatf("mismatch at %0t ns: colour during blanking", $time));

   // ack changes at the edge after the one that saw req
   ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(ack) |-> $past(req)
   ) else abort_run($sformatf("mismatch at %0t ns: ack rose with req low", $time));

   ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(ack) |-> !$past(req)
   ) else abort_run($sformatf("mismatch at %0t ns: ack fell with req high", $time));

   ack_delay: assert property (@(posedge clk) disable iff (!arst_n)
      hand_wait <= 2
   ) else abort_run($sformatf("mismatch at %0t ns: ack late by %0d cycles",
                              $time, $sampled(hand_wait)));

   pixel_color: assert property (@(posedge clk) disable iff (!arst_n)
      cmp_valid |-> (got_color == exp_color)
   ) else abort_run($sformatf("mismatch at %0t ns: pixel %0d shows %0d, expected %0d",
                              $time, $sampled(cmp_idx), $sampled(got_color),
                              $sampled(exp_color)));

   // reset, three frames and the writes all fit below the limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         abort_run("timeout: display did not finish");
      end
   end

   initial begin
      logic [31:0] rnd;
      logic [13:0] addr;
      arst_n   = 1'b1;
      req      = 1'b0;
      wr_addr  = '0;
      wr_color = '0;
      #1 arst_n = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // corners, then row 0 in column order, then anywhere
      for (int n = 0; n < N_WRITES; n++) begin
         rnd = $random(seed);
         if (n < 4) begin
            addr = 14'((n[1] ? ROWS - 1 : 0) * COLS + (n[0] ? COLS - 1 : 0));
         end else if (n < 4 + COLS) begin
            addr = 14'(n - 4);
         end else begin
            addr = rnd[29:16];
         end
         write_pixel(addr, rnd[2:0]);
      end

      wait (frames == 3);   // frames one and two fully observed
      if (checked_px != 2 * model.num()) begin
         abort_run($sformatf("only %0d of %0d written pixels were shown",
                             checked_px, 2 * model.num()));
      end else begin
         $display("test passed");
         $finish;
      end
   end

endmodule

// ==== fb_display.f ====
+incdir+verilog
verilog/fb_pkg.sv
verilog/fb_scan_if.sv
verilog/scan_timing.sv
verilog/plane_ram.sv
verilog/host_write.sv
verilog/pixel_stage.sv
verilog/fb_display.sv
tests/fb_display_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the framebuffer testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f fb_display.f --top-module fb_display_tb \
   --Mdir obj_dir -o fb_display_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "build failed with status $status"
   exit "$status"
fi

./obj_dir/fb_display_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation ended with status $status"
fi
exit "$status"
